// ==== Makefile ====
# Verilator build for the video memory subsystem

VERILATOR  = verilator
TOP        = tb_video_mem
FILELIST   = sources.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = All checks passed
VFLAGS     = --timing --assert
LINT_FLAGS = --lint-only $(VFLAGS)
SIM_FLAGS  = --binary $(VFLAGS) -Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hw/host_regs.sv ====
/*
 * Host register file.
 * Write and read pointers with auto-increment, display start address,
 * read prefetch latch and busy status. Data register accesses become
 * one pending VRAM command that is held until the arbiter answers.
 */
`timescale 1ns/1ns
`include "vram_defines.svh"

module host_regs
    import vram_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      bus_sel,
    input  logic      bus_wr,
    input  reg_num_t  bus_reg,
    input  vword_t    bus_data_in,
    output vword_t    bus_data_out,
    output vaddr_t    disp_start,
    output logic      host_req,
    output vram_cmd_t host_cmd,
    input  logic      host_done,
    input  vword_t    host_rdata
);

    vaddr_t wr_ptr;
    vaddr_t rd_ptr;
    vword_t prefetch;       // word at rd_ptr, ready for the next data read
    logic   wr_access;
    logic   rd_access;
    logic   data_wr;
    logic   data_rd;
    logic   rd_addr_wr;

    assign wr_access  = bus_sel && bus_wr;
    assign rd_access  = bus_sel && !bus_wr;
    assign data_wr    = wr_access && (bus_reg == `REG_DATA);
    assign data_rd    = rd_access && (bus_reg == `REG_DATA);
    assign rd_addr_wr = wr_access && (bus_reg == `REG_RD_ADDR);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            disp_start <= '0;
            host_req   <= 1'b0;
        end else begin
            if (host_done) begin
                host_req <= 1'b0;
            end
            if (wr_access) begin
                case (bus_reg)
                    `REG_WR_ADDR: wr_ptr <= bus_data_in;
                    `REG_RD_ADDR: begin
                        rd_ptr   <= bus_data_in;
                        host_req <= 1'b1;           // prefetch from new pointer
                    end
                    `REG_DATA: begin
                        wr_ptr   <= wr_ptr + 1'b1;
                        host_req <= 1'b1;
                    end
                    `REG_CTRL: disp_start <= bus_data_in;
                endcase
            end
            if (data_rd) begin
                rd_ptr   <= rd_ptr + 1'b1;
                host_req <= 1'b1;                   // refill the latch
            end
        end
    end

    // command payload and prefetch latch
    always_ff @(posedge clk) begin
        if (rd_addr_wr) begin
            host_cmd <= '{wr: 1'b0, addr: bus_data_in, wdata: '0};
        end else if (data_wr) begin
            host_cmd <= '{wr: 1'b1, addr: wr_ptr, wdata: bus_data_in};
        end else if (data_rd) begin
            host_cmd <= '{wr: 1'b0, addr: rd_ptr + 1'b1, wdata: '0};
        end
        if (host_done && !host_cmd.wr) begin
            prefetch <= host_rdata;
        end
    end

    // read data, valid the cycle after bus_sel
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus_data_out <= '0;
        end else if (rd_access) begin
            case (bus_reg)
                `REG_WR_ADDR: bus_data_out <= wr_ptr;
                `REG_RD_ADDR: bus_data_out <= rd_ptr;
                `REG_DATA:    bus_data_out <= prefetch;
                `REG_CTRL:    bus_data_out <= {15'b0, host_req};   // busy in bit 0
            endcase
        end
    end

    // host must poll busy low before touching the data path again
    a_no_access_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (bus_sel && ((bus_reg == `REG_DATA) || (bus_wr && bus_reg == `REG_RD_ADDR)))
        |-> !host_req);

endmodule

// ==== hw/line_fetch.sv ====
/*
 * Display line fetcher.
 * On vid_start, reads LINE_WORDS words from the display start address
 * in order. A one-word buffer sits ahead of the shift register, so
 * after the first pixel the 4-bit pixels come on back-to-back cycles,
 * msb nibble first. line_done pulses after the last pixel.
 */
`timescale 1ns/1ns
`include "vram_defines.svh"

module line_fetch
    import vram_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   vid_start,
    input  vaddr_t disp_start,
    output logic   fetch_req,
    output vaddr_t fetch_addr,
    input  logic   fetch_done,
    input  vword_t fetch_rdata,
    output logic   pix_valid,
    output pixel_t pixel,
    output logic   line_done
);

    typedef logic [$clog2(`LINE_WORDS)-1:0] word_cnt_t;

    fetch_state_t state;
    word_cnt_t    reqs_left;    // fetches still to issue
    word_cnt_t    words_left;   // words still to move into the shifter
    logic [1:0]   nib_cnt;      // pixel within current word
    vword_t       buf_word;
    vword_t       shreg;
    logic         word_load;    // shifter takes a new word at this edge
    logic         issue;

    assign word_load = (state == request && fetch_done) ||
                       (state == shift && nib_cnt == 2'd3 && words_left != '0);
    assign issue     = word_load && (reqs_left != '0);   // one fetch per word shifted
    assign pixel     = shreg[$bits(vword_t)-1 -: `PIX_BITS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= idle;
            fetch_req  <= 1'b0;
            fetch_addr <= '0;
            reqs_left  <= '0;
            words_left <= '0;
            nib_cnt    <= '0;
            pix_valid  <= 1'b0;
            line_done  <= 1'b0;
        end else begin
            line_done <= 1'b0;
            fetch_req <= issue;
            if (fetch_req) begin
                fetch_addr <= fetch_addr + 1'b1;    // served the same cycle
            end
            if (issue) begin
                reqs_left <= reqs_left - 1'b1;
            end
            case (state)
                idle: begin
                    if (vid_start) begin
                        fetch_addr <= disp_start;
                        fetch_req  <= 1'b1;
                        reqs_left  <= word_cnt_t'(`LINE_WORDS - 1);
                        state      <= request;
                    end
                end
                request: begin
                    if (fetch_done) begin
                        pix_valid  <= 1'b1;
                        nib_cnt    <= '0;
                        words_left <= word_cnt_t'(`LINE_WORDS - 1);
                        state      <= shift;
                    end
                end
                shift: begin
                    nib_cnt <= nib_cnt + 1'b1;
                    if (nib_cnt == 2'd3) begin
                        if (words_left != '0) begin
                            words_left <= words_left - 1'b1;
                        end else begin
                            pix_valid <= 1'b0;      // last pixel just went out
                            line_done <= 1'b1;
                            state     <= idle;
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // word buffer and pixel shifter
    always_ff @(posedge clk) begin
        if (fetch_done && state == shift) begin
            buf_word <= fetch_rdata;
        end
        if (word_load) begin
            shreg <= (state == request) ? fetch_rdata : buf_word;
        end else if (state == shift) begin
            shreg <= shreg << `PIX_BITS;
        end
    end

    a_no_pixels_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state == idle && !pix_valid) |=> !pix_valid);

endmodule

// ==== hw/video_mem_top.sv ====
/*
 * Video memory subsystem top level.
 * Host register file and line fetcher share the banked VRAM
 * through the arbiter.
 */
`timescale 1ns/1ns

module video_mem_top
    import vram_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     bus_sel,
    input  logic     bus_wr,
    input  reg_num_t bus_reg,
    input  vword_t   bus_data_in,
    output vword_t   bus_data_out,
    input  logic     vid_start,
    output logic     pix_valid,
    output pixel_t   pixel,
    output logic     line_done
);

    vaddr_t    disp_start;
    logic      host_req;
    vram_cmd_t host_cmd;
    logic      host_done;
    vword_t    host_rdata;
    logic      fetch_req;
    vaddr_t    fetch_addr;
    logic      fetch_done;
    vword_t    fetch_rdata;

    host_regs u_host_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus_sel      (bus_sel),
        .bus_wr       (bus_wr),
        .bus_reg      (bus_reg),
        .bus_data_in  (bus_data_in),
        .bus_data_out (bus_data_out),
        .disp_start   (disp_start),
        .host_req     (host_req),
        .host_cmd     (host_cmd),
        .host_done    (host_done),
        .host_rdata   (host_rdata)
    );

    vram_arbiter u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_done  (fetch_done),
        .fetch_rdata (fetch_rdata),
        .host_req    (host_req),
        .host_cmd    (host_cmd),
        .host_done   (host_done),
        .host_rdata  (host_rdata)
    );

    line_fetch u_line_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .vid_start   (vid_start),
        .disp_start  (disp_start),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_done  (fetch_done),
        .fetch_rdata (fetch_rdata),
        .pix_valid   (pix_valid),
        .pixel       (pixel),
        .line_done   (line_done)
    );

endmodule

// ==== hw/vram.sv ====
/*
 * Banked video RAM, 64K x 16.
 * Four 16K banks picked by the top address bits. Synchronous write,
 * read of the old data in the same cycle. The bank of the last access
 * is registered and selects which bank drives rdata.
 */
`timescale 1ns/1ns
`include "vram_defines.svh"

module vram
    import vram_pkg::*;
(
    input  logic   clk,
    input  logic   sel,
    input  logic   wr_en,
    input  vaddr_t address,
    input  vword_t wdata,
    output vword_t rdata
);

    logic [`VRAM_BANK_BITS-1:0]            bank_sel;
    logic [`VRAM_BANK_BITS-1:0]            read_bank;   // bank of last access
    logic [`VRAM_AW-`VRAM_BANK_BITS-1:0]   bank_addr;
    vword_t                                bank_rdata [1 << `VRAM_BANK_BITS];

    assign bank_sel  = address[`VRAM_AW-1 -: `VRAM_BANK_BITS];
    assign bank_addr = address[`VRAM_AW-`VRAM_BANK_BITS-1:0];

    for (genvar b = 0; b < (1 << `VRAM_BANK_BITS); b++) begin : g_bank
        vword_t mem [1 << (`VRAM_AW - `VRAM_BANK_BITS)];
        vword_t q;
        logic   bank_en;

        assign bank_en = sel && (int'(bank_sel) == b);

        // every word starts out as the fill pattern
        initial begin
            for (int i = 0; i < (1 << (`VRAM_AW - `VRAM_BANK_BITS)); i++) begin
                mem[i] = `VRAM_FILL;
            end
        end

        always_ff @(posedge clk) begin
            if (bank_en) begin
                if (wr_en) begin
                    mem[bank_addr] <= wdata;
                end
                q <= mem[bank_addr];        // old data on a write
            end
        end

        assign bank_rdata[b] = q;
    end

    always_ff @(posedge clk) begin
        if (sel) begin
            read_bank <= bank_sel;
        end
    end

    assign rdata = bank_rdata[read_bank];

endmodule

// ==== hw/vram_arbiter.sv ====
/*
 * VRAM port arbiter.
 * The line fetcher always wins and is served in the cycle it asks.
 * The host access goes out when the port is free. The owner of the
 * access in flight is registered so the read data returns to it
 * with its done pulse.
 */
`timescale 1ns/1ns

module vram_arbiter
    import vram_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      fetch_req,
    input  vaddr_t    fetch_addr,
    output logic      fetch_done,
    output vword_t    fetch_rdata,
    input  logic      host_req,
    input  vram_cmd_t host_cmd,
    output logic      host_done,
    output vword_t    host_rdata
);

    logic   host_go;        // host access issued this cycle
    logic   fetch_owner;    // fetch access in flight
    logic   host_owner;     // host access in flight
    logic   ram_sel;
    logic   ram_wr_en;
    vaddr_t ram_addr;
    vword_t ram_rdata;

    // host_req stays up through its done cycle, so don't reissue then
    assign host_go   = host_req && !fetch_req && !host_owner;
    assign ram_sel   = fetch_req || host_go;
    assign ram_wr_en = host_go && host_cmd.wr;
    assign ram_addr  = fetch_req ? fetch_addr : host_cmd.addr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_owner <= 1'b0;
            host_owner  <= 1'b0;
        end else begin
            fetch_owner <= fetch_req;
            host_owner  <= host_go;
        end
    end

    assign fetch_done  = fetch_owner;
    assign host_done   = host_owner;
    assign fetch_rdata = fetch_owner ? ram_rdata : '0;
    assign host_rdata  = host_owner ? ram_rdata : '0;

    vram u_vram (
        .clk     (clk),
        .sel     (ram_sel),
        .wr_en   (ram_wr_en),
        .address (ram_addr),
        .wdata   (host_cmd.wdata),
        .rdata   (ram_rdata)
    );

    // a waiting host gets the port right after any fetch cycle
    a_host_not_starved: assert property (@(posedge clk) disable iff (!rst_n)
        (fetch_req && host_req) |=> !fetch_req);

endmodule

// ==== hw/vram_pkg.sv ====
/*
 * Video memory types.
 * Address, data, pixel and register number vectors, the packed
 * command that carries one VRAM access, and the line fetch states.
 */
`include "vram_defines.svh"

package vram_pkg;

    typedef logic [`VRAM_AW-1:0]  vaddr_t;      // VRAM word address
    typedef logic [15:0]          vword_t;      // VRAM data word
    typedef logic [`PIX_BITS-1:0] pixel_t;      // palette index
    typedef logic [1:0]           reg_num_t;    // host register select

    // one VRAM access from the host side, 33 bits
    typedef struct packed {
        logic   wr;         // 1 = write, 0 = read
        vaddr_t addr;
        vword_t wdata;      // don't care on reads
    } vram_cmd_t;

    // line fetcher states
    typedef enum logic [1:0] {
        idle,       // waiting for vid_start
        request,    // first word of the line in flight
        shift       // pixels streaming out
    } fetch_state_t;

endpackage

// ==== include/vram_defines.svh ====
/*
 * Video memory subsystem constants.
 * Address and bank geometry of the VRAM, display line length,
 * pixel size, simulation fill value and host register numbers.
 */
`ifndef VRAM_DEFINES_SVH
`define VRAM_DEFINES_SVH

`define VRAM_AW         16          // word address width, 64K words
`define VRAM_BANK_BITS  2           // top address bits select one of four banks

`define LINE_WORDS      8           // words fetched per display line
`define PIX_BITS        4           // 4 pixels per word, msb nibble first

`define VRAM_FILL       16'hdead    // power-up contents in simulation

// host register numbers
`define REG_WR_ADDR     2'd0
`define REG_RD_ADDR     2'd1
`define REG_DATA        2'd2
`define REG_CTRL        2'd3

`endif

// ==== sources.f ====
+incdir+include
hw/vram_pkg.sv
hw/vram.sv
hw/vram_arbiter.sv
hw/host_regs.sv
hw/line_fetch.sv
hw/video_mem_top.sv
tb/tb_video_mem.sv

// ==== tb/tb_video_mem.sv ====
/*
 * Testbench for the video memory subsystem.
 * Random host traffic from a fixed seed is checked against a 64K-word
 * memory model, and display lines are checked pixel by pixel.
 * Host accesses poll the busy bit before touching the data path.
 */
`timescale 1ns/1ns
`include "vram_defines.svh"

module tb_video_mem
    import vram_pkg::*;
();

    localparam int PIX_PER_WORD = 16 / `PIX_BITS;
    localparam int LINE_PIX     = `LINE_WORDS * PIX_PER_WORD;
    localparam int BURST_LEN    = 16;
    localparam int NUM_BANKS    = 1 << `VRAM_BANK_BITS;
    // tests take roughly 5000 cycles, limit is four times that
    localparam int MAX_CYCLES   = 20000;

    logic     clk;
    logic     rst_n;
    logic     bus_sel;
    logic     bus_wr;
    reg_num_t bus_reg;
    vword_t   bus_data_in;
    vword_t   bus_data_out;
    logic     vid_start;
    logic     pix_valid;
    pixel_t   pixel;
    logic     line_done;

    vword_t   model [1 << `VRAM_AW];    // expected VRAM contents
    pixel_t   pix_q [$];                // pixels of the current line
    integer   seed = 32'h0708_fdac;
    int       lines_seen   = 0;
    int       cycle_count  = 0;
    int       test_checks  = 0;
    int       test_errors  = 0;
    int       total_checks = 0;
    int       total_errors = 0;

    video_mem_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus_sel      (bus_sel),
        .bus_wr       (bus_wr),
        .bus_reg      (bus_reg),
        .bus_data_in  (bus_data_in),
        .bus_data_out (bus_data_out),
        .vid_start    (vid_start),
        .pix_valid    (pix_valid),
        .pixel        (pixel),
        .line_done    (line_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    // pixel and line_done capture, away from the driving edge
    always @(negedge clk) begin
        if (pix_valid) begin
            pix_q.push_back(pixel);
        end
        if (line_done) begin
            lines_seen++;
        end
    end

    function automatic vword_t rand_word();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    task automatic check(input string name, input vword_t expected, input vword_t actual);
        test_checks++;
        if (expected !== actual) begin
            test_errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic bus_write(input reg_num_t r, input vword_t d);
        @(posedge clk);
        bus_sel     <= 1'b1;
        bus_wr      <= 1'b1;
        bus_reg     <= r;
        bus_data_in <= d;
        @(posedge clk);
        bus_sel <= 1'b0;
        bus_wr  <= 1'b0;
    endtask

    // data is loaded at the strobe edge, sampled half a cycle later
    task automatic bus_read(input reg_num_t r, output vword_t d);
        @(posedge clk);
        bus_sel <= 1'b1;
        bus_wr  <= 1'b0;
        bus_reg <= r;
        @(posedge clk);
        bus_sel <= 1'b0;
        @(negedge clk);
        d = bus_data_out;
    endtask

    task automatic wait_idle();
        vword_t st;
        do begin
            bus_read(`REG_CTRL, st);
        end while (st[0]);
    endtask

    task automatic host_write_word(input vaddr_t a, input vword_t d);
        wait_idle();
        bus_write(`REG_WR_ADDR, a);
        bus_write(`REG_DATA, d);
        model[a] = d;
    endtask

    task automatic host_read_word(input vaddr_t a, output vword_t d);
        wait_idle();
        bus_write(`REG_RD_ADDR, a);
        wait_idle();
        bus_read(`REG_DATA, d);
    endtask

    task automatic write_burst(input vaddr_t start, input int n);
        vword_t d;
        vaddr_t a;
        wait_idle();
        bus_write(`REG_WR_ADDR, start);
        for (int i = 0; i < n; i++) begin
            d = rand_word();
            a = start + vaddr_t'(i);
            wait_idle();
            bus_write(`REG_DATA, d);
            model[a] = d;
        end
    endtask

    task automatic start_line(input vaddr_t start, output int lines_before);
        bus_write(`REG_CTRL, start);
        pix_q.delete();
        lines_before = lines_seen;
        @(posedge clk);
        vid_start <= 1'b1;
        @(posedge clk);
        vid_start <= 1'b0;
    endtask

    task automatic check_line(input string name, input vaddr_t start, input int lines_before);
        vaddr_t a;
        vword_t w;
        int     sh;
        while (lines_seen == lines_before) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);         // a second line_done would show here
        check({name, " line_done"}, 16'd1, vword_t'(lines_seen - lines_before));
        check({name, " count"}, vword_t'(LINE_PIX), vword_t'(pix_q.size()));
        for (int i = 0; i < pix_q.size() && i < LINE_PIX; i++) begin
            a  = start + vaddr_t'(i / PIX_PER_WORD);
            w  = model[a];
            sh = (PIX_PER_WORD - 1 - i % PIX_PER_WORD) * `PIX_BITS;   // msb nibble first
            check($sformatf("%s pixel %0d", name, i),
                  vword_t'(w[sh +: `PIX_BITS]), vword_t'(pix_q[i]));
        end
    endtask

    initial begin
        vword_t st;
        vword_t d;
        vaddr_t start;
        vaddr_t a;
        int     lines_before;

        for (int i = 0; i < (1 << `VRAM_AW); i++) begin
            model[i] = `VRAM_FILL;
        end
        rst_n       <= 1'b0;
        bus_sel     <= 1'b0;
        bus_wr      <= 1'b0;
        bus_reg     <= '0;
        bus_data_in <= '0;
        vid_start   <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // reset state, no pixels without vid_start
        bus_read(`REG_CTRL, st);
        check("reset status", 16'd0, st);
        repeat (16) @(posedge clk);
        check("idle pixels", 16'd0, vword_t'(pix_q.size()));
        check("idle line_done", 16'd0, vword_t'(lines_seen));
        end_test("reset");

        // burst write then read back through the prefetch latch
        start = rand_word();
        write_burst(start, BURST_LEN);
        wait_idle();
        bus_write(`REG_RD_ADDR, start);
        for (int i = 0; i < BURST_LEN; i++) begin
            a = start + vaddr_t'(i);
            wait_idle();
            bus_read(`REG_DATA, d);
            check($sformatf("burst word %0d", i), model[a], d);
        end
        bus_read(`REG_WR_ADDR, d);
        check("burst wr_ptr", start + vaddr_t'(BURST_LEN), d);
        bus_read(`REG_RD_ADDR, d);
        check("burst rd_ptr", start + vaddr_t'(BURST_LEN), d);
        end_test("burst");

        // one address per bank, fresh read then write and read back
        for (int b = 0; b < NUM_BANKS; b++) begin
            d = rand_word();
            a = {b[`VRAM_BANK_BITS-1:0], d[`VRAM_AW-`VRAM_BANK_BITS-1:0]};
            host_read_word(a, st);
            check($sformatf("bank %0d fresh", b), model[a], st);
            host_write_word(a, rand_word());
            host_read_word(a, st);
            check($sformatf("bank %0d written", b), model[a], st);
            a = a ^ vaddr_t'(16'h0040);      // nearby word, likely untouched
            host_read_word(a, st);
            check($sformatf("bank %0d other", b), model[a], st);
        end
        end_test("banks");

        // one line over written data, one over fill
        for (int n = 0; n < 2; n++) begin
            start = rand_word();
            if (n == 0) begin
                write_burst(start, `LINE_WORDS);
            end
            wait_idle();
            start_line(start, lines_before);
            check_line($sformatf("line %0d", n), start, lines_before);
        end
        end_test("lines");

        // host traffic while a line streams, kept clear of the line words
        start = rand_word();
        write_burst(start, `LINE_WORDS);
        wait_idle();
        start_line(start, lines_before);
        for (int i = 0; i < 4; i++) begin
            a = start + vaddr_t'(16'h0100 + i);
            host_write_word(a, rand_word());
            host_read_word(a, d);
            check($sformatf("shared word %0d", i), model[a], d);
        end
        check_line("shared line", start, lines_before);
        end_test("shared");

        $display("total: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
